// File: vlog.f
+incdir+testbench
logic/alloc_pkg.sv
logic/general_register_file.sv
logic/system_register_file.sv
logic/operand_select.sv
logic/stage_register.sv
logic/allocate_stage.sv
testbench/tb_allocate.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the allocate stage testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_allocate -o tb_allocate
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_allocate > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
	exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]       lcg_state = 32'h2a3f;
logic [DATA_W-1:0] gr_model [GR_COUNT];
sysreg_view_t      sys_model;
int                check_count = 0;
int                error_count = 0;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Register state after one clock edge with the given bus and events
task automatic apply_edge(input wb_t w, input event_t e);
	sysreg_view_t s;
	s = sys_model;
	if (w.valid && !e.hold) begin
		if (w.writeback && !w.destination_sysreg) begin
			gr_model[w.destination] = w.data;
		end
		if (w.writeback && w.destination_sysreg) begin
			case (w.destination)
				SYSREG_SPR:  s.spr = w.data;
				SYSREG_PSR:  s.psr = w.data;
				SYSREG_PPSR: s.ppsr = w.data;
				SYSREG_PPCR: s.ppcr = w.data;
				SYSREG_IDTR: s.idtr = w.data;
				default:     ;
			endcase
		end
		if (w.spr_writeback) begin
			s.spr = w.spr;
		end
		s.pcr = w.pc;
	end
	// Events take priority
	if (e.irq_enter) begin
		s.psr  = sys_model.psr & ~32'h0000_0064;
		s.ppsr = sys_model.psr;
	end else if (e.irq_return) begin
		s.psr = sys_model.ppsr;
	end
	if (e.pcr_set || e.event_end) begin
		s.pcr = e.pcr;
	end
	if (e.ppcr_set && e.event_end) begin
		s.ppcr = e.ppcr;
	end
	sys_model = s;
endtask

task automatic check_word(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	check_count++;
	assert (actual === expected) else begin
		error_count++;
		$display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
	end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
	check_count++;
	assert (actual === expected) else begin
		error_count++;
		$display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
	end
endtask

task automatic check_true(input string what, input logic cond);
	check_count++;
	assert (cond === 1'b1) else begin
		error_count++;
		$display("Error at %0t: %s", $time, what);
	end
endtask

task automatic check_sysregs();
	check_word("sysreg.pcr", sysreg.pcr, sys_model.pcr);
	check_word("sysreg.psr", sysreg.psr, sys_model.psr);
	check_word("sysreg.spr", sysreg.spr, sys_model.spr);
	check_word("sysreg.idtr", sysreg.idtr, sys_model.idtr);
	check_word("sysreg.ppsr", sysreg.ppsr, sys_model.ppsr);
	check_word("sysreg.ppcr", sysreg.ppcr, sys_model.ppcr);
endtask

`endif

// File: testbench/tb_allocate.sv
`timescale 1ns/1ps

module tb_allocate;
	import alloc_pkg::*;

	localparam int PERIOD      = 40;
	localparam int TEST_CYCLES = 40;

	logic         iCLOCK;
	logic         inRESET;
	prev_op_t     prev;
	logic         prev_lock;
	wb_t          wb;
	event_t       events;
	next_op_t     next;
	logic         next_valid;
	logic         next_lock;
	sysreg_view_t sysreg;

	`include "tb_model.svh"

	allocate_stage UUT (.*);

	always #(PERIOD / 2) iCLOCK = ~iCLOCK;

	initial begin
		#(PERIOD * (TEST_CYCLES + 20));
		$display("Timeout: the tests did not complete in the expected time");
		$display("ERRORS FOUND");
		$finish;
	end

	// Edge, then update the model and return the strobes to idle
	task automatic tick();
		@(posedge iCLOCK);
		#2;
		apply_edge(wb, events);
		wb     = '0;
		events = '0;
	endtask

	function automatic prev_op_t instruction(input logic [4:0] src0, input logic sys0,
			input logic [31:0] src1, input logic sys1, input logic imm);
		prev_op_t op;
		op                 = '0;
		op.valid           = 1'b1;
		op.destination     = 5'd12;
		op.writeback       = 1'b1;
		op.flags_writeback = 1'b1;
		op.cmd             = 5'd3;
		op.cc_afe          = 4'ha;
		op.source0         = src0;
		op.source0_active  = 1'b1;
		op.source0_sysreg  = sys0;
		op.source1         = src1;
		op.source1_active  = 1'b1;
		op.source1_sysreg  = sys1;
		op.source1_imm     = imm;
		op.pc              = lcg_next() & ~32'h3;
		return op;
	endfunction

	function automatic wb_t writeback_to(input logic [4:0] dest, input logic sys,
			input logic [31:0] data);
		wb_t w;
		w                    = '0;
		w.valid              = 1'b1;
		w.writeback          = 1'b1;
		w.destination        = dest;
		w.destination_sysreg = sys;
		w.data               = data;
		w.pc                 = lcg_next();
		return w;
	endfunction

	task automatic check_instruction(input logic [31:0] exp0, input logic [31:0] exp1);
		check_bit("next_valid", next_valid, 1'b1);
		check_word("next.source0", next.source0, exp0);
		check_word("next.source1", next.source1, exp1);
		check_word("next.source0_pointer", {27'd0, next.source0_pointer}, {27'd0, prev.source0});
		check_word("next.source1_pointer", {27'd0, next.source1_pointer},
			{27'd0, prev.source1[4:0]});
		check_word("next.pc", next.pc, prev.pc);
		check_word("next.destination", {27'd0, next.destination},
			{27'd0, prev.destination});
		check_word("next.cmd", {27'd0, next.cmd}, {27'd0, prev.cmd});
		check_word("next.cc_afe", {28'd0, next.cc_afe}, {28'd0, prev.cc_afe});
		check_bit("next.destination_sysreg", next.destination_sysreg,
			prev.destination_sysreg);
		check_bit("next.writeback", next.writeback, prev.writeback);
		check_bit("next.flags_writeback", next.flags_writeback, prev.flags_writeback);
		check_bit("next.source0_sysreg", next.source0_sysreg, prev.source0_sysreg);
		check_bit("next.source1_sysreg", next.source1_sysreg, prev.source1_sysreg);
		check_bit("next.source1_imm", next.source1_imm, prev.source1_imm);
	endtask

	task automatic reset_state();
		check_bit("next_valid", next_valid, 1'b0);
		check_sysregs();
	endtask

	task automatic general_registers();
		logic [31:0] imm;
		for (int i = 1; i < 8; i++) begin
			wb = writeback_to(i[4:0], 1'b0, lcg_next());
			tick();
		end
		for (int i = 1; i < 7; i++) begin
			prev = instruction(i[4:0], 1'b0, 32'(i + 1), 1'b0, 1'b0);
			tick();
			check_instruction(gr_model[i], gr_model[i + 1]);
		end
		imm  = lcg_next();
		prev = instruction(5'd3, 1'b0, imm, 1'b0, 1'b1);
		tick();
		check_instruction(gr_model[3], imm);
		prev.valid = 1'b0;
	endtask

	task automatic forwarding_and_hold();
		logic [31:0] data;
		logic [31:0] imm;
		data = lcg_next();
		wb   = writeback_to(5'd9, 1'b0, data);
		prev = instruction(5'd9, 1'b0, 32'd9, 1'b0, 1'b0);
		tick();
		check_instruction(data, data);
		// Write under hold must be dropped
		wb          = writeback_to(5'd9, 1'b0, ~data);
		events.hold = 1'b1;
		prev        = instruction(5'd1, 1'b0, 32'd2, 1'b0, 1'b0);
		prev.valid  = 1'b0;
		tick();
		prev = instruction(5'd9, 1'b0, 32'd9, 1'b0, 1'b0);
		tick();
		check_instruction(data, data);
		imm  = (lcg_next() & ~32'h1f) | 32'd9;
		wb   = writeback_to(5'd9, 1'b0, lcg_next());
		prev = instruction(5'd1, 1'b0, imm, 1'b0, 1'b1);
		tick();
		check_instruction(gr_model[1], imm);
		prev.valid = 1'b0;
	endtask

	task automatic system_registers();
		wb = writeback_to(SYSREG_IDTR, 1'b1, lcg_next());
		tick();
		wb = writeback_to(SYSREG_PSR, 1'b1, lcg_next());
		tick();
		wb = writeback_to(SYSREG_PPSR, 1'b1, lcg_next());
		tick();
		wb               = writeback_to(5'd20, 1'b0, 32'd0);
		wb.writeback     = 1'b0;
		wb.spr_writeback = 1'b1;
		wb.spr           = lcg_next();
		tick();
		check_sysregs();
		prev = instruction(SYSREG_PSR, 1'b1, 32'(SYSREG_IDTR), 1'b1, 1'b0);
		tick();
		check_instruction(sys_model.psr, sys_model.idtr);
		prev = instruction(SYSREG_SPR, 1'b1, 32'(SYSREG_PPSR), 1'b1, 1'b0);
		tick();
		check_instruction(sys_model.spr, sys_model.ppsr);
		// Index 7 is not a system register
		prev = instruction(SYSREG_PCR, 1'b1, 32'd7, 1'b1, 1'b0);
		tick();
		check_instruction(prev.pc - 32'd4, gr_model[7]);
		prev.valid = 1'b0;
	endtask

	task automatic processor_events();
		logic [31:0] old_psr;
		wb = writeback_to(SYSREG_PSR, 1'b1, lcg_next() | 32'h64);
		tick();
		old_psr          = sys_model.psr;
		events.irq_enter = 1'b1;
		tick();
		check_word("sysreg.psr", sysreg.psr, old_psr & ~32'h64);
		check_word("sysreg.ppsr", sysreg.ppsr, old_psr);
		events.irq_return = 1'b1;
		tick();
		check_word("sysreg.psr", sysreg.psr, old_psr);
		events.pcr_set = 1'b1;
		events.pcr     = lcg_next();
		tick();
		check_sysregs();
		events.event_end = 1'b1;
		events.ppcr_set  = 1'b1;
		events.pcr       = lcg_next();
		events.ppcr      = lcg_next();
		tick();
		check_sysregs();
		prev = instruction(5'd1, 1'b0, 32'd2, 1'b0, 1'b0);
		tick();
		check_bit("next_valid", next_valid, 1'b1);
		events.start = 1'b1;
		tick();
		check_bit("next_valid", next_valid, 1'b0);
		prev.valid = 1'b0;
	endtask

	task automatic lock_stall();
		next_op_t held;
		prev = instruction(5'd1, 1'b0, 32'd2, 1'b0, 1'b0);
		tick();
		check_instruction(gr_model[1], gr_model[2]);
		held      = next;
		next_lock = 1'b1;
		prev      = instruction(5'd3, 1'b0, 32'd4, 1'b0, 1'b0);
		#1;
		check_bit("prev_lock", prev_lock, 1'b1);
		check_bit("next_valid", next_valid, 1'b0);
		tick();
		tick();
		check_bit("prev_lock", prev_lock, 1'b1);
		check_bit("next_valid", next_valid, 1'b0);
		check_true("next changed while the stage was locked", next === held);
		next_lock = 1'b0;
		#1;
		check_bit("prev_lock", prev_lock, 1'b0);
		check_bit("next_valid", next_valid, 1'b1);
		check_true("held instruction lost after the lock was released", next === held);
		tick();
		check_instruction(gr_model[3], gr_model[4]);
		prev.valid = 1'b0;
	endtask

	initial begin
		iCLOCK    = 1'b0;
		inRESET   = 1'b0;
		prev      = '0;
		wb        = '0;
		events    = '0;
		next_lock = 1'b0;
		sys_model = '0;
		repeat (3) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		reset_state();
		general_registers();
		forwarding_and_hold();
		system_registers();
		processor_events();
		lock_stall();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: logic/allocate_stage.sv
`timescale 1ns/1ps

module allocate_stage (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  alloc_pkg::prev_op_t     prev,
	output logic                    prev_lock,
	input  alloc_pkg::wb_t          wb,
	input  alloc_pkg::event_t       events,
	output alloc_pkg::next_op_t     next,
	output logic                    next_valid,
	input  logic                    next_lock,
	output alloc_pkg::sysreg_view_t sysreg
);
	import alloc_pkg::*;

	logic              gr_wr_en;
	logic [DATA_W-1:0] gr_data0;
	logic [DATA_W-1:0] gr_data1;
	logic [DATA_W-1:0] operand0;
	logic [DATA_W-1:0] operand1;
	next_op_t          resolved;

	assign prev_lock = next_lock;

	assign gr_wr_en = wb.valid && wb.writeback && !wb.destination_sysreg && !events.hold;

	general_register_file u_grf (
		.iCLOCK   (iCLOCK),
		.wr_en    (gr_wr_en),
		.wr_addr  (wb.destination),
		.wr_data  (wb.data),
		.rd0_addr (prev.source0),
		.rd0_data (gr_data0),
		.rd1_addr (prev.source1[REG_ADDR_W-1:0]),
		.rd1_data (gr_data1)
	);

	system_register_file u_srf (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.wb      (wb),
		.events  (events),
		.view    (sysreg)
	);

	// Source 0 never carries an immediate
	operand_select src0_sel (
		.index   (prev.source0),
		.active  (prev.source0_active),
		.sysreg  (prev.source0_sysreg),
		.imm_en  (1'b0),
		.imm     ('0),
		.pc      (prev.pc),
		.gr_data (gr_data0),
		.view    (sysreg),
		.wb      (wb),
		.operand (operand0)
	);

	operand_select src1_sel (
		.index   (prev.source1[REG_ADDR_W-1:0]),
		.active  (prev.source1_active),
		.sysreg  (prev.source1_sysreg),
		.imm_en  (prev.source1_imm),
		.imm     (prev.source1),
		.pc      (prev.pc),
		.gr_data (gr_data1),
		.view    (sysreg),
		.wb      (wb),
		.operand (operand1)
	);

	always_comb begin
		resolved.destination        = prev.destination;
		resolved.destination_sysreg = prev.destination_sysreg;
		resolved.writeback          = prev.writeback;
		resolved.flags_writeback    = prev.flags_writeback;
		resolved.cmd                = prev.cmd;
		resolved.cc_afe             = prev.cc_afe;
		resolved.source0            = operand0;
		resolved.source1            = operand1;
		resolved.source0_pointer    = prev.source0;
		resolved.source1_pointer    = prev.source1[REG_ADDR_W-1:0];
		resolved.source0_sysreg     = prev.source0_sysreg;
		resolved.source1_sysreg     = prev.source1_sysreg;
		resolved.source1_imm        = prev.source1_imm;
		resolved.pc                 = prev.pc;
	end

	stage_register u_stage (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.start      (events.start),
		.lock       (next_lock),
		.in_op      (resolved),
		.in_valid   (prev.valid),
		.out_op     (next),
		.next_valid (next_valid)
	);

endmodule

// File: logic/stage_register.sv
`timescale 1ns/1ps

module stage_register (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic                start,
	input  logic                lock,
	input  alloc_pkg::next_op_t in_op,
	input  logic                in_valid,
	output alloc_pkg::next_op_t out_op,
	output logic                next_valid
);
	import alloc_pkg::*;

	next_op_t op_q;
	logic     valid_q;

	// Valid bit
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
		end else if (start) begin
			valid_q <= 1'b0;
		end else if (!lock) begin
			valid_q <= in_valid;
		end
	end

	// Instruction payload
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			op_q <= '0;
		end else if (start) begin
			op_q <= '0;
		end else if (!lock) begin
			op_q <= in_op;
		end
	end

	assign out_op = op_q;

	// Nothing is offered downstream while it is stalled
	assign next_valid = valid_q && !lock;

endmodule

// File: logic/operand_select.sv
`timescale 1ns/1ps

module operand_select (
	input  logic [alloc_pkg::REG_ADDR_W-1:0] index,
	input  logic                             active,
	input  logic                             sysreg,
	input  logic                             imm_en,
	input  logic [alloc_pkg::DATA_W-1:0]     imm,
	input  logic [alloc_pkg::DATA_W-1:0]     pc,
	input  logic [alloc_pkg::DATA_W-1:0]     gr_data,
	input  alloc_pkg::sysreg_view_t          view,
	input  alloc_pkg::wb_t                   wb,
	output logic [alloc_pkg::DATA_W-1:0]     operand
);
	import alloc_pkg::*;

	logic              fwd_hit;
	logic [DATA_W-1:0] fwd_data;
	logic              sys_known;
	logic [DATA_W-1:0] sys_data;

	// Bypass from the writeback bus
	always_comb begin
		fwd_hit  = 1'b0;
		fwd_data = wb.data;
		if (wb.valid) begin
			if (sysreg) begin
				if (wb.destination_sysreg) begin
					if (index == SYSREG_PCR) begin
						fwd_hit  = 1'b1;
						fwd_data = wb.pc;
					end else if (index == SYSREG_SPR && wb.spr_writeback) begin
						fwd_hit  = 1'b1;
						fwd_data = wb.spr;
					end else if (index == wb.destination && wb.writeback) begin
						fwd_hit  = 1'b1;
						fwd_data = wb.data;
					end
				end
			end else if (index == wb.destination && !wb.destination_sysreg && wb.writeback) begin
				fwd_hit = 1'b1;
			end
		end
	end

	// System register lookup
	always_comb begin
		sys_known = 1'b1;
		case (index)
			SYSREG_SPR:  sys_data = view.spr;
			SYSREG_PSR:  sys_data = view.psr;
			// Stored PCR runs ahead, use the instruction's own address
			SYSREG_PCR:  sys_data = pc - PC_STEP;
			SYSREG_PPSR: sys_data = view.ppsr;
			SYSREG_PPCR: sys_data = view.ppcr;
			SYSREG_IDTR: sys_data = view.idtr;
			default: begin
				sys_known = 1'b0;
				sys_data  = '0;
			end
		endcase
	end

	always_comb begin
		if (imm_en) begin
			operand = imm;
		end else if (fwd_hit) begin
			operand = fwd_data;
		end else if (sysreg && active && sys_known) begin
			operand = sys_data;
		end else begin
			operand = gr_data;
		end
	end

endmodule

// File: logic/system_register_file.sv
`timescale 1ns/1ps

module system_register_file (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  alloc_pkg::wb_t          wb,
	input  alloc_pkg::event_t       events,
	output alloc_pkg::sysreg_view_t view
);
	import alloc_pkg::*;

	sysreg_view_t regs_q;
	sysreg_view_t regs_d;

	logic wb_active;
	logic wb_sys_wr;
	logic wb_spr_wr;
	logic wr_psr;
	logic wr_spr;
	logic wr_idtr;
	logic wr_ppsr;
	logic wr_ppcr;
	logic pcr_load;
	logic ppcr_load;

	// Writeback strobes, all suppressed during hold
	assign wb_active = wb.valid && !events.hold;
	assign wb_sys_wr = wb_active && wb.writeback && wb.destination_sysreg;
	assign wb_spr_wr = wb_active && wb.spr_writeback;

	assign wr_psr  = wb_sys_wr && (wb.destination == SYSREG_PSR);
	assign wr_spr  = wb_sys_wr && (wb.destination == SYSREG_SPR);
	assign wr_idtr = wb_sys_wr && (wb.destination == SYSREG_IDTR);
	assign wr_ppsr = wb_sys_wr && (wb.destination == SYSREG_PPSR);
	assign wr_ppcr = wb_sys_wr && (wb.destination == SYSREG_PPCR);

	// Event loads
	assign pcr_load  = events.pcr_set || events.event_end;
	assign ppcr_load = events.ppcr_set && events.event_end;

	always_comb begin
		regs_d = regs_q;

		// PCR follows the retiring instruction unless an event redirects it
		if (pcr_load) begin
			regs_d.pcr = events.pcr;
		end else if (wb_active) begin
			regs_d.pcr = wb.pc;
		end

		if (events.irq_enter) begin
			regs_d.psr = regs_q.psr & PSR_IRQ_CLEAR_MASK;
		end else if (events.irq_return) begin
			regs_d.psr = regs_q.ppsr;
		end else if (wr_psr) begin
			regs_d.psr = wb.data;
		end

		// Stack pointer update from load/store beats a plain write
		if (wb_spr_wr) begin
			regs_d.spr = wb.spr;
		end else if (wr_spr) begin
			regs_d.spr = wb.data;
		end

		if (wr_idtr) begin
			regs_d.idtr = wb.data;
		end

		// Old PSR saved on interrupt entry
		if (events.irq_enter) begin
			regs_d.ppsr = regs_q.psr;
		end else if (wr_ppsr) begin
			regs_d.ppsr = wb.data;
		end

		if (ppcr_load) begin
			regs_d.ppcr = events.ppcr;
		end else if (wr_ppcr) begin
			regs_d.ppcr = wb.data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			regs_q <= '0;
		end else begin
			regs_q <= regs_d;
		end
	end

	assign view = regs_q;

endmodule

// File: logic/general_register_file.sv
`timescale 1ns/1ps

module general_register_file (
	input  logic                            iCLOCK,
	input  logic                            wr_en,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [alloc_pkg::DATA_W-1:0]     wr_data,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] rd0_addr,
	output logic [alloc_pkg::DATA_W-1:0]     rd0_data,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] rd1_addr,
	output logic [alloc_pkg::DATA_W-1:0]     rd1_data
);
	import alloc_pkg::*;

	logic [DATA_W-1:0] regs [GR_COUNT];

	// Single write port
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Read ports see the stored value, bypass is done in operand_select
	assign rd0_data = regs[rd0_addr];
	assign rd1_data = regs[rd1_addr];

endmodule

// File: logic/alloc_pkg.sv
package alloc_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int GR_COUNT   = 32;
	localparam int CMD_W      = 5;
	localparam int CC_W       = 4;

	// PCR reads as the address of the current instruction
	localparam logic [DATA_W-1:0] PC_STEP = 32'd4;

	// Clears PSR bits 6, 5 and 2 on interrupt entry
	localparam logic [DATA_W-1:0] PSR_IRQ_CLEAR_MASK = 32'hffff_ff9b;

	// System register indices
	localparam logic [REG_ADDR_W-1:0] SYSREG_SPR  = 5'd0;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PSR  = 5'd1;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PCR  = 5'd2;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PPSR = 5'd3;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PPCR = 5'd4;
	localparam logic [REG_ADDR_W-1:0] SYSREG_IDTR = 5'd5;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] destination;
		logic                  destination_sysreg;
		logic                  writeback;
		logic                  flags_writeback;
		logic [CMD_W-1:0]      cmd;
		logic [CC_W-1:0]       cc_afe;
		logic [REG_ADDR_W-1:0] source0;
		logic                  source0_active;
		logic                  source0_sysreg;
		// Register index in the low bits, or the immediate
		logic [DATA_W-1:0]     source1;
		logic                  source1_active;
		logic                  source1_sysreg;
		logic                  source1_imm;
		logic [DATA_W-1:0]     pc;
	} prev_op_t;

	typedef struct packed {
		logic [REG_ADDR_W-1:0] destination;
		logic                  destination_sysreg;
		logic                  writeback;
		logic                  flags_writeback;
		logic [CMD_W-1:0]      cmd;
		logic [CC_W-1:0]       cc_afe;
		logic [DATA_W-1:0]     source0;
		logic [DATA_W-1:0]     source1;
		logic [REG_ADDR_W-1:0] source0_pointer;
		logic [REG_ADDR_W-1:0] source1_pointer;
		logic                  source0_sysreg;
		logic                  source1_sysreg;
		logic                  source1_imm;
		logic [DATA_W-1:0]     pc;
	} next_op_t;

	typedef struct packed {
		logic                  valid;
		logic [DATA_W-1:0]     data;
		logic [REG_ADDR_W-1:0] destination;
		logic                  destination_sysreg;
		logic                  writeback;
		logic                  spr_writeback;
		logic [DATA_W-1:0]     spr;
		logic [DATA_W-1:0]     pc;
	} wb_t;

	typedef struct packed {
		logic              hold;
		logic              start;
		logic              irq_enter;
		logic              irq_return;
		logic              event_end;
		logic              pcr_set;
		logic [DATA_W-1:0] pcr;
		logic              ppcr_set;
		logic [DATA_W-1:0] ppcr;
	} event_t;

	typedef struct packed {
		logic [DATA_W-1:0] pcr;
		logic [DATA_W-1:0] psr;
		logic [DATA_W-1:0] spr;
		logic [DATA_W-1:0] idtr;
		logic [DATA_W-1:0] ppsr;
		logic [DATA_W-1:0] ppcr;
	} sysreg_view_t;

endpackage
